// ==== Makefile ====
# Verilator build and run of the localbus configuration testbench

TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = lbus_cfg_tb
FILE_LIST = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SHELL := /bin/bash

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

# a fail message anywhere in the log makes the target fail
run: compile
	set -o pipefail; ./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== build.f ====
+incdir+logic
logic/lbus_pkg.sv
logic/lbus_reg_bank.sv
logic/lbus_dispatch.sv
logic/lbus_cfg_top.sv
verif/lbus_cfg_assertions.sv
verif/lbus_cfg_tb.sv

// ==== logic/lbus_cfg_top.sv ====
// localbus configuration path: dispatcher plus one register bank per region
// the host drives the localbus pins, everything else is internal

`timescale 1ns/100ps

`include "lbus_settings.svh"

module lbus_cfg_top
    import lbus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // host localbus
    input  logic       ctrl_cs_n,
    input  logic       ctrl_rd,
    input  lbus_addr_t ctrl_addr,
    input  lbus_data_t ctrl_wdata,
    output logic       ctrl_ack_n,
    output lbus_data_t ctrl_rdata
);

    // **********************************************************************
    // dispatcher to bank wiring
    // **********************************************************************

    lbus_sel_t     bank_cs_n;
    lbus_sel_t     bank_ack_n;
    logic          bank_rd;
    lbus_reg_idx_t bank_addr;
    lbus_data_t    bank_wdata;
    lbus_data_t    bank_rdata [`LBUS_REGION_CNT];

    lbus_dispatch u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl_cs_n  (ctrl_cs_n),
        .ctrl_rd    (ctrl_rd),
        .ctrl_addr  (ctrl_addr),
        .ctrl_wdata (ctrl_wdata),
        .ctrl_ack_n (ctrl_ack_n),
        .ctrl_rdata (ctrl_rdata),
        .bank_cs_n  (bank_cs_n),
        .bank_rd    (bank_rd),
        .bank_addr  (bank_addr),
        .bank_wdata (bank_wdata),
        .bank_ack_n (bank_ack_n),
        .bank_rdata (bank_rdata)
    );

    // **********************************************************************
    // register banks
    // **********************************************************************

    // bank i serves region i
    genvar gi;
    generate
        for (gi = 0; gi < `LBUS_REGION_CNT; gi++) begin : g_bank
            lbus_reg_bank u_bank (
                .clk   (clk),
                .rst_n (rst_n),
                .cs_n  (bank_cs_n[gi]),
                .rd    (bank_rd),
                .addr  (bank_addr),
                .wdata (bank_wdata),
                .ack_n (bank_ack_n[gi]),
                .rdata (bank_rdata[gi])
            );
        end
    endgenerate

endmodule

// ==== logic/lbus_dispatch.sv ====
// host localbus dispatcher: synchronises chip-select, decodes the region and
// runs one access against the selected register bank

`timescale 1ns/100ps

`include "lbus_settings.svh"

module lbus_dispatch
    import lbus_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,

    // host side
    input  logic          ctrl_cs_n,
    input  logic          ctrl_rd,
    input  lbus_addr_t    ctrl_addr,
    input  lbus_data_t    ctrl_wdata,
    output logic          ctrl_ack_n,
    output lbus_data_t    ctrl_rdata,

    // bank side
    output lbus_sel_t     bank_cs_n,
    output logic          bank_rd,
    output lbus_reg_idx_t bank_addr,
    output lbus_data_t    bank_wdata,
    input  lbus_sel_t     bank_ack_n,
    input  lbus_data_t    bank_rdata [`LBUS_REGION_CNT]
);

    // **********************************************************************
    // chip-select synchroniser
    // **********************************************************************

    // host select arrives asynchronous to clk, shifted in as active high
    logic [`LBUS_SYNC_STAGES-1:0] cs_sync;
    logic                         cs_active;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs_sync <= '0;
        end else begin
            cs_sync <= {cs_sync[`LBUS_SYNC_STAGES-2:0], ~ctrl_cs_n};
        end
    end

    assign cs_active = cs_sync[`LBUS_SYNC_STAGES-1];

    // **********************************************************************
    // command capture
    // **********************************************************************

    lbus_state_t state;
    logic        cmd_rd;
    lbus_addr_t  cmd_addr;
    lbus_data_t  cmd_wdata;
    logic        start_cmd;

    // new command only when no bank still holds an acknowledge
    assign start_cmd = (state == st_idle) && cs_active && (&bank_ack_n);

    // host keeps these stable while its select is low
    always_ff @(posedge clk) begin
        if (start_cmd) begin
            cmd_rd    <= ctrl_rd;
            cmd_addr  <= ctrl_addr;
            cmd_wdata <= ctrl_wdata;
        end
    end

    // shared bank buses come straight from the captured command
    assign bank_rd    = cmd_rd;
    assign bank_addr  = lbus_reg_idx_t'(cmd_addr);
    assign bank_wdata = cmd_wdata;

    // **********************************************************************
    // region decode
    // **********************************************************************

    lbus_region_t region;
    lbus_sel_t    region_sel;
    logic         region_hit;
    logic         sel_ack;

    assign region = cmd_addr[`LBUS_REGION_MSB:`LBUS_REGION_LSB];

    // regions past the last bank shift out and leave an empty select
    assign region_sel = lbus_sel_t'(1) << region;
    assign region_hit = |region_sel;

    // acknowledge from the bank that is currently selected
    assign sel_ack = |(~bank_ack_n & ~bank_cs_n);

    // **********************************************************************
    // transaction FSM
    // **********************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            bank_cs_n  <= '1;
            ctrl_rdata <= '0;
        end else begin
            case (state)
                st_idle: begin
                    bank_cs_n <= '1;
                    if (start_cmd) begin
                        state <= st_decode;
                    end
                end

                st_decode: begin
                    if (region_hit) begin
                        bank_cs_n <= ~region_sel;
                        state     <= st_wait_ack;
                    end else begin
                        // unmapped region completes at once with zero data
                        ctrl_rdata <= '0;
                        state      <= st_release;
                    end
                end

                st_wait_ack: begin
                    // no fixed latency assumed here, just wait for the bank
                    if (sel_ack) begin
                        bank_cs_n  <= '1;
                        ctrl_rdata <= bank_rdata[region];
                        state      <= st_release;
                    end
                end

                st_release: begin
                    // hold until the host lets go of its select
                    if (!cs_active) begin
                        state <= st_idle;
                    end
                end

                default: begin
                    bank_cs_n <= '1;
                    state     <= st_idle;
                end
            endcase
        end
    end

    // **********************************************************************
    // host acknowledge
    // **********************************************************************

    // low in st_release for as long as the synchronised select is active
    assign ctrl_ack_n = ~((state == st_release) && cs_active);

endmodule

// ==== logic/lbus_pkg.sv ====
// shared types of the localbus configuration bridge
// imported by the dispatcher, the register banks and the top level

`include "lbus_settings.svh"

package lbus_pkg;

    // **********************************************************************
    // bus vectors
    // **********************************************************************
    typedef logic [`LBUS_DATA_W-1:0] lbus_data_t;
    typedef logic [`LBUS_ADDR_W-1:0] lbus_addr_t;

    // region number taken from the address
    typedef logic [`LBUS_REGION_MSB-`LBUS_REGION_LSB:0] lbus_region_t;

    // one bit per region, chip-selects and acknowledges
    typedef logic [`LBUS_REGION_CNT-1:0] lbus_sel_t;

    // word index inside one bank
    typedef logic [$clog2(`LBUS_REG_WORDS)-1:0] lbus_reg_idx_t;

    // **********************************************************************
    // dispatcher FSM
    // **********************************************************************
    typedef enum logic [1:0] {
        st_idle,
        st_decode,
        st_wait_ack,
        st_release
    } lbus_state_t;

endpackage

// ==== logic/lbus_reg_bank.sv ====
// configuration register file standing in for one stage's registers
// answers each chip-select with a one-cycle acknowledge and a read word

`timescale 1ns/100ps

`include "lbus_settings.svh"

module lbus_reg_bank
    import lbus_pkg::*;
#(
    parameter lbus_data_t RESET_VALUE = '0
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          cs_n,
    input  logic          rd,
    input  lbus_reg_idx_t addr,
    input  lbus_data_t    wdata,
    output logic          ack_n,
    output lbus_data_t    rdata
);

    lbus_data_t regs [`LBUS_REG_WORDS];
    logic       access;

    // select is ignored while the previous acknowledge is still low
    assign access = ~cs_n & ack_n;

    // **********************************************************************
    // register array
    // **********************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `LBUS_REG_WORDS; i++) begin
                regs[i] <= RESET_VALUE;
            end
        end else if (access && !rd) begin
            regs[addr] <= wdata;
        end
    end

    // **********************************************************************
    // acknowledge and read word
    // **********************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_n <= 1'b1;
        end else begin
            ack_n <= ~access;
        end
    end

    // a write returns the value just written
    always_ff @(posedge clk) begin
        if (access) begin
            if (rd) begin
                rdata <= regs[addr];
            end else begin
                rdata <= wdata;
            end
        end
    end

endmodule

// ==== logic/lbus_settings.svh ====
// widths, region map and bank size of the localbus configuration bridge
// include this wherever one of the macros is used

`ifndef LBUS_SETTINGS_SVH
`define LBUS_SETTINGS_SVH

// host bus widths
`define LBUS_DATA_W         32
`define LBUS_ADDR_W         32

// region field inside the host address
`define LBUS_REGION_MSB     15
`define LBUS_REGION_LSB     13
`define LBUS_REGION_CNT     6

// registers held by each region bank
`define LBUS_REG_WORDS      16

// chip-select synchroniser depth
`define LBUS_SYNC_STAGES    2

`endif

// ==== verif/lbus_cfg_assertions.sv ====
// handshake checks on the localbus dispatcher
// bound into every lbus_dispatch instance, violations raise $error

`timescale 1ns/100ps

`include "lbus_settings.svh"

module lbus_cfg_assertions
    import lbus_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input lbus_state_t state,
    input logic        ctrl_cs_n,
    input lbus_sel_t   bank_cs_n,
    input lbus_sel_t   bank_ack_n,
    input logic        ctrl_ack_n
);

    // a bank is selected only while the FSM waits for it, and never two at once
    one_bank_selected: assert property (
        @(posedge clk) disable iff (!rst_n)
            !(&bank_cs_n) |-> $onehot(~bank_cs_n) && (state == st_wait_ack)
    ) else $error("bank chip-select low outside st_wait_ack or more than one low");

    // host acknowledge falls only as the FSM enters st_release from an access
    ack_only_in_release: assert property (
        @(posedge clk) disable iff (!rst_n)
            $fell(ctrl_ack_n) |-> (state == st_release)
                                  && ($past(state) inside {st_decode, st_wait_ack})
    ) else $error("ctrl_ack_n fell without the FSM entering st_release");

    // selected bank answered, its select must be gone next cycle
    select_drops_after_ack: assert property (
        @(posedge clk) disable iff (!rst_n) |(~bank_ack_n & ~bank_cs_n) |=> &bank_cs_n
    ) else $error("bank chip-select still low the cycle after its acknowledge");

    // host select as seen through the synchroniser delay
    ack_high_without_select: assert property (
        @(posedge clk) disable iff (!rst_n)
            !ctrl_ack_n |-> !$past(ctrl_cs_n, `LBUS_SYNC_STAGES)
    ) else $error("ctrl_ack_n low while the synchronised select is inactive");

endmodule

bind lbus_dispatch lbus_cfg_assertions u_assertions (
    .clk        (clk),
    .rst_n      (rst_n),
    .state      (state),
    .ctrl_cs_n  (ctrl_cs_n),
    .bank_cs_n  (bank_cs_n),
    .bank_ack_n (bank_ack_n),
    .ctrl_ack_n (ctrl_ack_n)
);

// ==== verif/lbus_cfg_tb.sv ====
// directed testbench for the localbus configuration bridge
// host accesses are driven on the falling edge and checked against a shadow model

`timescale 1ns/100ps

`include "lbus_settings.svh"

module lbus_cfg_tb
    import lbus_pkg::*;
();

    localparam int CLK_HALF     = 20;
    localparam int CLK_PERIOD   = 2 * CLK_HALF;
    localparam int RESET_CYCLES = 5;
    localparam int SEED         = 1763;
    localparam int RANDOM_COUNT = 200;
    localparam int HOLD_COUNT   = 8;
    localparam int ACK_LIMIT    = 32;
    localparam int REGIONS      = `LBUS_REGION_CNT;
    localparam int WORDS        = `LBUS_REG_WORDS;
    localparam int REGION_SPACE = 1 << (`LBUS_REGION_MSB - `LBUS_REGION_LSB + 1);
    localparam int ALL_WORDS    = REGIONS * WORDS;

    // reset sweep, write/read, isolation, unmapped plus sweep, handshake, random
    localparam int ACCESS_COUNT = ALL_WORDS + 2 * REGIONS + 2 * REGIONS
                                + 2 * (REGION_SPACE - REGIONS) + ALL_WORDS
                                + HOLD_COUNT + RANDOM_COUNT;
    localparam int WATCHDOG_NS  = ACCESS_COUNT * 40 * CLK_PERIOD + 100 * CLK_PERIOD;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       ctrl_cs_n;
    logic       ctrl_rd;
    lbus_addr_t ctrl_addr;
    lbus_data_t ctrl_wdata;
    logic       ctrl_ack_n;
    lbus_data_t ctrl_rdata;

    int checks   = 0;
    int errors   = 0;
    int timeouts = 0;

    // expected register contents
    lbus_data_t model [REGIONS][WORDS];

    lbus_cfg_top u_lbus_cfg_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl_cs_n  (ctrl_cs_n),
        .ctrl_rd    (ctrl_rd),
        .ctrl_addr  (ctrl_addr),
        .ctrl_wdata (ctrl_wdata),
        .ctrl_ack_n (ctrl_ack_n),
        .ctrl_rdata (ctrl_rdata)
    );

    always #(CLK_HALF) clk = ~clk;

    // **********************************************************************
    // host bus driver
    // **********************************************************************

    function automatic lbus_addr_t make_addr(input int region, input int idx);
        lbus_addr_t addr;
        addr = '0;
        addr[`LBUS_REGION_MSB:`LBUS_REGION_LSB] = lbus_region_t'(region);
        addr[$bits(lbus_reg_idx_t)-1:0] = lbus_reg_idx_t'(idx);
        return addr;
    endfunction

    task automatic check_data(input lbus_data_t got, input lbus_data_t exp, input string what);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("FAIL %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // one full transaction, select held for hold extra cycles after the acknowledge
    task automatic run_access(input logic rd, input int region, input int idx,
                              input lbus_data_t wdata, input int hold,
                              output lbus_data_t rdata);
        int waited;
        @(negedge clk);
        ctrl_rd    = rd;
        ctrl_addr  = make_addr(region, idx);
        ctrl_wdata = wdata;
        ctrl_cs_n  = 1'b0;
        waited = 0;
        while (ctrl_ack_n !== 1'b0 && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (ctrl_ack_n !== 1'b0) begin
            timeouts++;
            $display("ERROR: no acknowledge within %0d cycles for region %0d word %0d",
                     ACK_LIMIT, region, idx);
        end
        rdata = ctrl_rdata;
        repeat (hold) begin
            @(negedge clk);
            checks++;
            assert (ctrl_ack_n === 1'b0)
            else begin
                errors++;
                $display("FAIL %0t: ctrl_ack_n rose while ctrl_cs_n was held low", $time);
            end
        end
        ctrl_cs_n = 1'b1;
        waited = 0;
        while (ctrl_ack_n !== 1'b1 && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (ctrl_ack_n !== 1'b1) begin
            timeouts++;
            $display("ERROR: acknowledge stayed low %0d cycles after the select was released",
                     ACK_LIMIT);
        end
    endtask

    task automatic bus_write(input int region, input int idx, input lbus_data_t wdata,
                             input int hold, output lbus_data_t rdata);
        run_access(1'b0, region, idx, wdata, hold, rdata);
    endtask

    task automatic bus_read(input int region, input int idx, input int hold,
                            output lbus_data_t rdata);
        run_access(1'b1, region, idx, '0, hold, rdata);
    endtask

    // **********************************************************************
    // model checked accesses
    // **********************************************************************

    // mapped writes echo the new value, unmapped ones return zero
    task automatic write_and_check(input int region, input int idx, input lbus_data_t value,
                                   input int hold);
        lbus_data_t got;
        lbus_data_t exp;
        bus_write(region, idx, value, hold, got);
        exp = '0;
        if (region < REGIONS) begin
            model[region][idx] = value;
            exp = value;
        end
        check_data(got, exp, $sformatf("write region %0d word %0d", region, idx));
    endtask

    task automatic read_and_check(input int region, input int idx, input int hold);
        lbus_data_t got;
        lbus_data_t exp;
        bus_read(region, idx, hold, got);
        exp = '0;
        if (region < REGIONS) begin
            exp = model[region][idx];
        end
        check_data(got, exp, $sformatf("read region %0d word %0d", region, idx));
    endtask

    task automatic verify_all_banks();
        for (int r = 0; r < REGIONS; r++) begin
            for (int i = 0; i < WORDS; i++) begin
                read_and_check(r, i, 0);
            end
        end
    endtask

    // **********************************************************************
    // directed tests
    // **********************************************************************

    task automatic check_reset_values();
        checks++;
        assert (ctrl_ack_n === 1'b1)
        else begin
            errors++;
            $display("FAIL %0t: ctrl_ack_n not high after reset", $time);
        end
        check_data(ctrl_rdata, '0, "ctrl_rdata after reset");
        verify_all_banks();
    endtask

    task automatic write_read_each_region();
        int idx;
        for (int r = 0; r < REGIONS; r++) begin
            idx = $urandom_range(0, WORDS - 1);
            write_and_check(r, idx, $urandom, 0);
            read_and_check(r, idx, 0);
        end
    endtask

    // same word index everywhere, distinct value per region
    task automatic isolate_regions();
        int idx;
        idx = $urandom_range(0, WORDS - 1);
        for (int r = 0; r < REGIONS; r++) begin
            write_and_check(r, idx, 32'h5A5A_0000 + r + 1, 0);
        end
        for (int r = 0; r < REGIONS; r++) begin
            read_and_check(r, idx, 0);
        end
    endtask

    task automatic probe_unmapped();
        for (int r = REGIONS; r < REGION_SPACE; r++) begin
            write_and_check(r, $urandom_range(0, WORDS - 1), $urandom | 32'h1, 0);
            read_and_check(r, $urandom_range(0, WORDS - 1), 0);
        end
        verify_all_banks();
    endtask

    task automatic hold_select();
        int region;
        int idx;
        int hold;
        for (int n = 0; n < HOLD_COUNT; n++) begin
            region = $urandom_range(0, REGIONS - 1);
            idx    = $urandom_range(0, WORDS - 1);
            hold   = $urandom_range(0, 10);
            if (n % 2 == 0) begin
                write_and_check(region, idx, $urandom, hold);
            end else begin
                read_and_check(region, idx, hold);
            end
        end
    endtask

    // unmapped regions are part of the draw
    task automatic random_mix();
        int region;
        int idx;
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            region = $urandom_range(0, REGION_SPACE - 1);
            idx    = $urandom_range(0, WORDS - 1);
            if ($urandom_range(0, 1) == 1) begin
                read_and_check(region, idx, 0);
            end else begin
                write_and_check(region, idx, $urandom, 0);
            end
        end
    endtask

    task automatic print_counts();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    endtask

    // **********************************************************************
    // run control
    // **********************************************************************

    initial begin
        int unsigned seed_init;
        rst_n      = 1'b0;
        ctrl_cs_n  = 1'b1;
        ctrl_rd    = 1'b1;
        ctrl_addr  = '0;
        ctrl_wdata = '0;
        seed_init  = $urandom(SEED);
        for (int r = 0; r < REGIONS; r++) begin
            for (int i = 0; i < WORDS; i++) begin
                model[r][i] = '0;
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_reset_values();
        write_read_each_region();
        isolate_regions();
        probe_unmapped();
        hold_select();
        random_mix();

        print_counts();
        if (errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        print_counts();
        $display("Result: FAILED");
        $finish;
    end

endmodule
